// ==== logic/bringup_pkg.sv ====
// Defaults assume a 12 MHz board clock and 16 sensed pins; widths follow from these constants
`default_nettype none

package bringup_pkg;

	// Sensed pin bank
	localparam int PIN_COUNT = 16;
	localparam int PIN_INDEX_W = $clog2(PIN_COUNT);

	typedef logic [PIN_COUNT-1:0] pin_mask_t;
	typedef logic [7:0] report_char_t;

	// Report line characters
	localparam report_char_t CHAR_ACTIVE = 8'h31; // '1'
	localparam report_char_t CHAR_QUIET = 8'h2e; // '.'
	localparam report_char_t CHAR_CR = 8'h0d;
	localparam report_char_t CHAR_LF = 8'h0a;

	// 115200 baud and 10 Hz scans at 12 MHz
	localparam int DEF_CLOCKS_PER_BAUD = 104;
	localparam int DEF_CLOCKS_PER_SCAN = 1200000;

	// Probe square wave
	localparam int DRIVE_HALF_PERIOD = 16;
	localparam int DRIVE_CNT_W = $clog2(DRIVE_HALF_PERIOD);

	localparam int SYNC_STAGES = 2; // Flops per pin before edge detect

	typedef enum logic [1:0] {
		REP_IDLE,
		REP_PIN,
		REP_CR,
		REP_LF
	} reporter_state_t;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

endpackage

`default_nettype wire

// ==== logic/bringup_timebase.sv ====
// CLOCKS_PER_SCAN must be at least 2 so the strobe stays a single-cycle pulse
`timescale 1ns/1ps
`default_nettype none

module bringup_timebase
	import bringup_pkg::*;
#(
	parameter int CLOCKS_PER_SCAN = DEF_CLOCKS_PER_SCAN
) (
	input  wire  clock_i,
	input  wire  rst_n_i,
	output logic scan_strobe_o,
	output logic probe_o
);

	logic [$clog2(CLOCKS_PER_SCAN)-1:0] scan_cnt_q;
	logic [DRIVE_CNT_W-1:0] drive_cnt_q;

	// Scan period counter with the strobe on the last count
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			scan_cnt_q <= '0;
			scan_strobe_o <= 1'b0;
		end else if (int'(scan_cnt_q) == CLOCKS_PER_SCAN - 1) begin
			scan_cnt_q <= '0;
			scan_strobe_o <= 1'b1;
		end else begin
			scan_cnt_q <= scan_cnt_q + 1'b1;
			scan_strobe_o <= 1'b0;
		end
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			drive_cnt_q <= '0;
			probe_o <= 1'b0;
		end else if (drive_cnt_q == DRIVE_CNT_W'(DRIVE_HALF_PERIOD - 1)) begin
			drive_cnt_q <= '0;
			probe_o <= ~probe_o; // Half period done
		end else begin
			drive_cnt_q <= drive_cnt_q + 1'b1;
		end
	end

	// Reporter relies on a single pulse per scan
	a_strobe_one_cycle: assert property (
		@(posedge clock_i) disable iff (!rst_n_i)
		scan_strobe_o |=> !scan_strobe_o
	);

endmodule

`default_nettype wire

// ==== logic/activity_sensor_bank.sv ====
// Pins are asynchronous; an edge that lands in the clear cycle is dropped
`timescale 1ns/1ps
`default_nettype none

module activity_sensor_bank
	import bringup_pkg::*;
(
	input  wire       clock_i,
	input  wire       rst_n_i,
	input  pin_mask_t pins_i,
	input  wire       clear_i,
	output pin_mask_t activity_o
);

	pin_mask_t sync_q [SYNC_STAGES];
	pin_mask_t prev_q;
	pin_mask_t flags_q;
	pin_mask_t changed;

	// Synchronizer chain plus last settled level
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
			prev_q <= '0;
		end else begin
			sync_q[0] <= pins_i;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			prev_q <= sync_q[SYNC_STAGES-1];
		end
	end

	assign changed = sync_q[SYNC_STAGES-1] ^ prev_q;

	// Sticky until the reporter takes its snapshot
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			flags_q <= '0;
		end else if (clear_i) begin
			flags_q <= '0;
		end else begin
			flags_q <= flags_q | changed;
		end
	end

	assign activity_o = flags_q;

endmodule

`default_nettype wire

// ==== logic/scan_reporter.sv ====
// Strobes arriving mid-report are ignored; the UART must raise busy the cycle after a write
`timescale 1ns/1ps
`default_nettype none

module scan_reporter
	import bringup_pkg::*;
(
	input  wire          clock_i,
	input  wire          rst_n_i,
	input  wire          scan_strobe_i,
	input  pin_mask_t    activity_i,
	output logic         clear_o,
	input  wire          tx_busy_i,
	output logic         tx_write_o,
	output report_char_t tx_data_o
);

	reporter_state_t state_q;
	pin_mask_t snapshot_q;
	logic [PIN_INDEX_W-1:0] pin_idx_q;
	logic start;
	logic last_pin;

	assign start = scan_strobe_i && (state_q == REP_IDLE);
	assign clear_o = start; // Bank zeroes flags as we latch them
	assign last_pin = (pin_idx_q == PIN_INDEX_W'(PIN_COUNT - 1));

	always_ff @(posedge clock_i) begin
		if (start) begin
			snapshot_q <= activity_i;
		end
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= REP_IDLE;
			pin_idx_q <= '0;
			tx_write_o <= 1'b0;
		end else begin
			// One write per idle window of the UART
			tx_write_o <= (state_q != REP_IDLE) && !tx_busy_i && !tx_write_o;

			if (start) begin
				state_q <= REP_PIN;
				pin_idx_q <= '0;
			end else if (tx_write_o) begin
				case (state_q)
					REP_PIN: begin
						if (last_pin) begin
							state_q <= REP_CR;
						end else begin
							pin_idx_q <= pin_idx_q + 1'b1;
						end
					end
					REP_CR: state_q <= REP_LF;
					REP_LF: state_q <= REP_IDLE; // Line done
					default: state_q <= REP_IDLE;
				endcase
			end
		end
	end

	// Character for the current position starting at pin 0
	always_comb begin
		case (state_q)
			REP_PIN: tx_data_o = snapshot_q[pin_idx_q] ? CHAR_ACTIVE : CHAR_QUIET;
			REP_CR: tx_data_o = CHAR_CR;
			REP_LF: tx_data_o = CHAR_LF;
			default: tx_data_o = CHAR_QUIET;
		endcase
	end

	// UART must never see a write while it is still shifting
	a_no_write_when_busy: assert property (
		@(posedge clock_i) disable iff (!rst_n_i)
		tx_write_o |-> !tx_busy_i
	);

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// 8N1 only, CLOCKS_PER_BAUD of at least 2; writes while busy are ignored
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import bringup_pkg::*;
#(
	parameter int CLOCKS_PER_BAUD = DEF_CLOCKS_PER_BAUD
) (
	input  wire          clock_i,
	input  wire          rst_n_i,
	input  wire          write_i,
	input  report_char_t data_i,
	output logic         busy_o,
	output logic         tx_o
);

	uart_state_t state_q;
	logic [$clog2(CLOCKS_PER_BAUD)-1:0] baud_cnt_q;
	logic [2:0] bit_cnt_q;
	report_char_t shift_q;
	logic tx_q;
	logic baud_done;

	assign baud_done = (int'(baud_cnt_q) == CLOCKS_PER_BAUD - 1);
	assign busy_o = (state_q != UART_IDLE);
	assign tx_o = tx_q;

	// Shift register sends the LSB first
	always_ff @(posedge clock_i) begin
		if (state_q == UART_IDLE && write_i) begin
			shift_q <= data_i;
		end else if (baud_done && (state_q == UART_START || state_q == UART_DATA)) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= UART_IDLE;
			baud_cnt_q <= '0;
			bit_cnt_q <= '0;
			tx_q <= 1'b1; // Line idles high
		end else begin
			if (state_q == UART_IDLE || baud_done) begin
				baud_cnt_q <= '0;
			end else begin
				baud_cnt_q <= baud_cnt_q + 1'b1;
			end

			case (state_q)
				UART_IDLE: begin
					if (write_i) begin
						state_q <= UART_START;
						tx_q <= 1'b0;
					end
				end
				UART_START: begin
					if (baud_done) begin
						state_q <= UART_DATA;
						bit_cnt_q <= '0;
						tx_q <= shift_q[0];
					end
				end
				UART_DATA: begin
					if (baud_done) begin
						if (bit_cnt_q == 3'd7) begin
							state_q <= UART_STOP;
							tx_q <= 1'b1;
						end else begin
							bit_cnt_q <= bit_cnt_q + 1'b1;
							tx_q <= shift_q[0];
						end
					end
				end
				UART_STOP: begin
					if (baud_done) begin
						state_q <= UART_IDLE;
					end
				end
				default: state_q <= UART_IDLE;
			endcase
		end
	end

	// Stop bit level must carry into idle
	a_idle_line_high: assert property (
		@(posedge clock_i) disable iff (!rst_n_i)
		(state_q == UART_IDLE) |-> tx_o
	);

endmodule

`default_nettype wire

// ==== logic/bringup_boundary.sv ====
// A full report line must fit inside one scan period or every other scan is skipped
`timescale 1ns/1ps
`default_nettype none

module bringup_boundary
	import bringup_pkg::*;
#(
	parameter int CLOCKS_PER_BAUD = DEF_CLOCKS_PER_BAUD,
	parameter int CLOCKS_PER_SCAN = DEF_CLOCKS_PER_SCAN
) (
	input  wire       clock_i,
	input  wire       rst_n_i,
	input  pin_mask_t pins_i,
	output logic      probe_o,
	output logic      uart_tx_o
);

	logic scan_strobe;
	pin_mask_t activity;
	logic clear;
	logic tx_write;
	report_char_t tx_data;
	logic tx_busy;

	bringup_timebase #(
		.CLOCKS_PER_SCAN(CLOCKS_PER_SCAN)
	) timebase0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.scan_strobe_o(scan_strobe),
		.probe_o(probe_o)
	);

	activity_sensor_bank sensors0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.pins_i(pins_i),
		.clear_i(clear),
		.activity_o(activity)
	);

	scan_reporter reporter0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.scan_strobe_i(scan_strobe),
		.activity_i(activity),
		.clear_o(clear),
		.tx_busy_i(tx_busy),
		.tx_write_o(tx_write),
		.tx_data_o(tx_data)
	);

	uart_tx #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
	) uart_tx0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.write_i(tx_write),
		.data_i(tx_data),
		.busy_o(tx_busy),
		.tx_o(uart_tx_o)
	);

endmodule

`default_nettype wire

// ==== sim/tb_bringup_boundary.sv ====
// Runs at 8 clocks per baud and 4000 clocks per scan; mask count must match the data file length
`timescale 1ns/1ps
`default_nettype none

module tb_bringup_boundary
	import bringup_pkg::*;
;

	localparam int BAUD_CLOCKS = 8;
	localparam int SCAN_CLOCKS = 4000;
	localparam int MASK_COUNT = 14;
	localparam int LINE_CHARS = PIN_COUNT + 2;
	localparam int TIMEOUT_CYCLES = (MASK_COUNT + 3) * SCAN_CLOCKS;

	logic clock_i;
	logic rst_n_i;
	logic [14:0] toggle_q; // Driven pins 14:0
	logic probe;
	logic uart_tx;
	pin_mask_t pins;

	logic [14:0] masks [MASK_COUNT];
	logic [14:0] expected_mask;
	int line_no;
	int mismatch_count;
	int fault_count;
	int cycle_count;
	int probe_gap;
	int probe_checks;
	logic probe_prev;
	logic probe_seen;

	assign pins = {probe, toggle_q}; // Probe loops back to pin 15

	bringup_boundary #(
		.CLOCKS_PER_BAUD(BAUD_CLOCKS),
		.CLOCKS_PER_SCAN(SCAN_CLOCKS)
	) UUT (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.pins_i(pins),
		.probe_o(probe),
		.uart_tx_o(uart_tx)
	);

	initial begin
		clock_i = 1'b0;
	end

	always #4 clock_i = ~clock_i;

	task automatic check_char(input string test_name, input report_char_t exp,
		input report_char_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %h actual %h", test_name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic check_probe(input string test_name, input int exp, input int act);
		if (exp != act) begin
			$display("MISMATCH %s: expected %0d actual %0d", test_name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic report_and_finish();
		$display("Closing: %0d mismatches, %0d other errors, %0d probe gaps checked",
			mismatch_count, fault_count, probe_checks);
		if (mismatch_count + fault_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	// Decodes one 8N1 frame, sampling near each bit center
	task automatic receive_byte(output report_char_t data);
		report_char_t shift;
		int bit_idx;
		shift = '0;
		@(negedge clock_i);
		while (uart_tx !== 1'b0)
			@(negedge clock_i);
		repeat (BAUD_CLOCKS / 2 - 1) @(negedge clock_i);
		if (uart_tx !== 1'b0) begin
			$display("Start bit of a frame was not low at its middle");
			fault_count++;
		end
		for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
			repeat (BAUD_CLOCKS) @(negedge clock_i);
			shift[bit_idx] = uart_tx; // LSB first
		end
		repeat (BAUD_CLOCKS) @(negedge clock_i);
		if (uart_tx !== 1'b1) begin
			$display("Stop bit of a frame was read low");
			fault_count++;
		end
		data = shift;
	endtask

	// Pins 0-14 follow the mask, pin 15 always active, then CR LF
	task automatic check_line(input int idx, input logic [14:0] mask, input string test_name);
		report_char_t got;
		report_char_t want;
		int pos;
		for (pos = 0; pos < LINE_CHARS; pos++) begin
			receive_byte(got);
			if (pos < 15) begin
				want = mask[pos] ? 8'h31 : 8'h2e;
			end else if (pos == 15) begin
				want = 8'h31;
			end else if (pos == 16) begin
				want = 8'h0d;
			end else begin
				want = 8'h0a;
			end
			check_char($sformatf("%s line %0d char %0d", test_name, idx, pos), want, got);
		end
	endtask

	initial begin
		toggle_q = '0;
		rst_n_i = 1'b0;
		mismatch_count = 0;
		fault_count = 0;
		$readmemh("sim/bringup_testdata.txt", masks);
		repeat (3) @(posedge clock_i);
		rst_n_i <= 1'b1;
		expected_mask = '0;
		for (line_no = 0; line_no <= MASK_COUNT; line_no++) begin
			if (line_no == 0) begin
				check_line(line_no, expected_mask, "first_report");
			end else if (line_no >= 2 && expected_mask == '0 && masks[line_no-2] != '0) begin
				check_line(line_no, expected_mask, "cleared_flags");
			end else begin
				check_line(line_no, expected_mask, "toggle_report");
			end
			if (line_no < MASK_COUNT) begin
				// Well clear of the next strobe
				@(posedge clock_i);
				toggle_q <= toggle_q ^ masks[line_no];
				expected_mask = masks[line_no];
			end
		end
		report_and_finish();
	end

	// Probe gap measured in clocks between edges
	always @(negedge clock_i) begin
		if (!rst_n_i) begin
			probe_gap = 0;
			probe_checks = 0;
			probe_prev = 1'b0;
			probe_seen = 1'b0;
		end else begin
			probe_gap++;
			if (probe !== probe_prev) begin
				if (probe_seen) begin
					check_probe("probe_period", DRIVE_HALF_PERIOD, probe_gap);
					probe_checks++;
				end
				probe_seen = 1'b1;
				probe_gap = 0;
				probe_prev = probe;
			end
		end
	end

	initial begin
		cycle_count = 0;
	end

	always @(posedge clock_i) begin
		cycle_count++;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout hit after %0d cycles before all report lines arrived", cycle_count);
			fault_count++;
			report_and_finish();
		end
	end

endmodule

`default_nettype wire

// ==== sim/bringup_testdata.txt ====
// One hex toggle mask per report line, bit i inverts pin i (pins 14:0)
// Each mask is applied once after the previous line's LF
0001
4000
0000
7fff
0000
2aaa
5555
0000
1234
0f0f
0000
7000
00ff
0000

// ==== verilog.f ====
logic/bringup_pkg.sv
logic/bringup_timebase.sv
logic/activity_sensor_bank.sv
logic/scan_reporter.sv
logic/uart_tx.sv
logic/bringup_boundary.sv
sim/tb_bringup_boundary.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module tb_bringup_boundary \
	--Mdir obj_dir \
	-o tb_bringup_boundary \
	&& ./obj_dir/tb_bringup_boundary > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat "$LOG"

grep -q "ERRORS FOUND" "$LOG" && { echo "Simulation reported failure"; exit 1; }

echo "Simulation passed"
exit 0
